// File: Makefile
# Verilator simulation of the accelerometer subsystem

VERILATOR ?= verilator
TOP       ?= tb_accel_top
RTL_TOP   ?= accel_top
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
LINTFLAGS ?= --lint-only --timing -Wall
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) \
		hw/accel_pkg.sv hw/accel_spi_reader.sv hw/axis_filter.sv \
		hw/motion_detector.sv hw/accel_top.sv

clean:
	rm -rf $(BUILD_DIR)

// File: hw/accel_pkg.sv
package accel_pkg;

    // one axis sample, also used for filtered values
    typedef logic signed [7:0] axis_t;
    // bit 2 is x, bit 1 is y, bit 0 is z
    typedef logic [2:0] axis_mask_t;

    typedef enum logic [1:0] {
        POWER_UP,
        FRAME,
        GAP
    } spi_state_t;

    localparam int NUM_AXES = 3;

    // burst read of the three axis registers
    localparam logic [7:0] READ_CMD   = 8'h0B;
    localparam logic [7:0] XDATA_ADDR = 8'h08;

    localparam int POWER_UP_CYCLES = 20000;
    localparam int GAP_CYCLES      = 10000;  // csn high between frames
    localparam int BIT_CYCLES      = 4;      // sclk = iclk / 4
    localparam int FRAME_BITS      = 40;
    localparam int TX_BITS         = 16;     // command + address
    localparam int RX_BITS         = 24;     // x, y, z bytes

    localparam int WAIT_W  = $clog2(POWER_UP_CYCLES);
    localparam int PHASE_W = $clog2(BIT_CYCLES);
    localparam int BIT_W   = $clog2(FRAME_BITS);

    localparam int AVG_DEPTH = 4;
    localparam int AVG_SHIFT = $clog2(AVG_DEPTH);
    localparam int SUM_W     = 10;  // room for four full-scale samples

    localparam int MOTION_THRESH = 16;
    localparam int DIFF_W        = 9;

endpackage

// File: hw/accel_spi_reader.sv
`timescale 1ns/1ps

module accel_spi_reader (
    input  logic             iclk,
    input  logic             arst_n,
    input  logic             miso,
    output logic             sclk,
    output logic             mosi,
    output logic             csn,
    output logic             sample_valid,
    output accel_pkg::axis_t x_data,
    output accel_pkg::axis_t y_data,
    output accel_pkg::axis_t z_data
);
    import accel_pkg::*;

    spi_state_t           state;
    logic [WAIT_W-1:0]    wait_cnt;
    logic [WAIT_W-1:0]    wait_end;
    logic [PHASE_W-1:0]   phase;     // position inside the current bit
    logic [BIT_W-1:0]     bit_idx;
    logic [TX_BITS-1:0]   tx_shift;
    logic [RX_BITS-1:0]   rx_shift;
    logic                 bit_end;
    logic                 last_bit;
    logic                 sclk_rise;
    logic                 frame_done;

    // power-up and gap share one counter
    assign wait_end = (state == POWER_UP) ? WAIT_W'(POWER_UP_CYCLES - 1)
                                          : WAIT_W'(GAP_CYCLES - 1);

    assign bit_end   = (phase == PHASE_W'(BIT_CYCLES - 1));
    assign last_bit  = (bit_idx == BIT_W'(FRAME_BITS - 1));
    assign sclk_rise = (state == FRAME) && (phase == PHASE_W'(BIT_CYCLES / 2 - 1));

    // first cycle of the gap, csn already high
    assign frame_done = (state == GAP) && (wait_cnt == '0);

    assign mosi = tx_shift[TX_BITS-1];  // zeros once cmd and addr are out

    always_ff @(posedge iclk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= POWER_UP;
            wait_cnt <= '0;
            phase    <= '0;
            bit_idx  <= '0;
            tx_shift <= '0;
            csn      <= 1'b1;
            sclk     <= 1'b0;
        end else begin
            case (state)
                POWER_UP, GAP: begin
                    if (wait_cnt == wait_end) begin
                        state    <= FRAME;
                        csn      <= 1'b0;
                        wait_cnt <= '0;
                        phase    <= '0;
                        bit_idx  <= '0;
                        tx_shift <= {READ_CMD, XDATA_ADDR};  // msb presented at csn fall
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                FRAME: begin
                    phase <= bit_end ? '0 : phase + 1'b1;
                    if (sclk_rise) begin
                        sclk <= 1'b1;
                    end
                    if (bit_end) begin
                        // falling edge, next mosi bit goes out with it
                        sclk     <= 1'b0;
                        tx_shift <= tx_shift << 1;
                        bit_idx  <= bit_idx + 1'b1;
                        if (last_bit) begin
                            state <= GAP;
                            csn   <= 1'b1;
                        end
                    end
                end
                default: begin
                    state <= POWER_UP;
                    csn   <= 1'b1;
                    sclk  <= 1'b0;
                end
            endcase
        end
    end

    // data bits follow the 16 command/address bits, msb first
    always_ff @(posedge iclk) begin
        if (sclk_rise && (bit_idx >= BIT_W'(TX_BITS))) begin
            rx_shift <= {rx_shift[RX_BITS-2:0], miso};
        end
    end

    // output latch, all three bytes change together
    always_ff @(posedge iclk or negedge arst_n) begin
        if (!arst_n) begin
            sample_valid <= 1'b0;
            x_data       <= '0;
            y_data       <= '0;
            z_data       <= '0;
        end else begin
            sample_valid <= frame_done;
            if (frame_done) begin
                x_data <= axis_t'(rx_shift[23:16]);
                y_data <= axis_t'(rx_shift[15:8]);
                z_data <= axis_t'(rx_shift[7:0]);
            end
        end
    end

    // mode 0 idle level outside the frame
    a_sclk_idle : assert property (@(posedge iclk) disable iff (!arst_n)
        csn |-> !sclk);

    a_valid_in_gap : assert property (@(posedge iclk) disable iff (!arst_n)
        sample_valid |-> csn);

endmodule

// File: hw/accel_top.sv
`timescale 1ns/1ps

module accel_top (
    input  logic                  iclk,
    input  logic                  arst_n,
    input  logic                  miso,
    output logic                  sclk,
    output logic                  mosi,
    output logic                  csn,
    output logic                  sample_valid,
    output accel_pkg::axis_t      x_data,
    output accel_pkg::axis_t      y_data,
    output accel_pkg::axis_t      z_data,
    output logic                  filt_valid,
    output accel_pkg::axis_t      filt_data [accel_pkg::NUM_AXES],  // [0] is x
    output logic                  motion,
    output accel_pkg::axis_mask_t motion_axes
);
    import accel_pkg::*;

    axis_t               sample_axes [NUM_AXES];
    logic [NUM_AXES-1:0] axis_valid;  // mask order, bit 2 is x

    accel_spi_reader accel_spi_reader_i (
        .iclk         (iclk),
        .arst_n       (arst_n),
        .miso         (miso),
        .sclk         (sclk),
        .mosi         (mosi),
        .csn          (csn),
        .sample_valid (sample_valid),
        .x_data       (x_data),
        .y_data       (y_data),
        .z_data       (z_data)
    );

    assign sample_axes[0] = x_data;
    assign sample_axes[1] = y_data;
    assign sample_axes[2] = z_data;

    for (genvar i = 0; i < NUM_AXES; i++) begin : g_axis
        axis_filter axis_filter_i (
            .iclk      (iclk),
            .arst_n    (arst_n),
            .in_valid  (sample_valid),
            .in_data   (sample_axes[i]),
            .avg_valid (axis_valid[NUM_AXES-1-i]),
            .avg_data  (filt_data[i])
        );
    end

    assign filt_valid = axis_valid[NUM_AXES-1];  // x filter, all three pulse together

    motion_detector motion_detector_i (
        .iclk        (iclk),
        .arst_n      (arst_n),
        .in_valid    (axis_valid),
        .in_data     (filt_data),
        .motion      (motion),
        .motion_axes (motion_axes)
    );

endmodule

// File: hw/axis_filter.sv
`timescale 1ns/1ps

module axis_filter (
    input  logic             iclk,
    input  logic             arst_n,
    input  logic             in_valid,
    input  accel_pkg::axis_t in_data,
    output logic             avg_valid,
    output accel_pkg::axis_t avg_data
);
    import accel_pkg::*;

    axis_t                   hist [AVG_DEPTH];  // [0] is newest
    logic signed [SUM_W-1:0] sum;
    logic signed [SUM_W-1:0] sum_next;

    // running sum, oldest sample falls out of the window
    assign sum_next = sum + in_data - hist[AVG_DEPTH-1];

    always_ff @(posedge iclk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < AVG_DEPTH; i++) begin
                hist[i] <= '0;
            end
            sum       <= '0;
            avg_valid <= 1'b0;
            avg_data  <= '0;
        end else begin
            avg_valid <= in_valid;
            if (in_valid) begin
                hist[0] <= in_data;
                for (int i = 1; i < AVG_DEPTH; i++) begin
                    hist[i] <= hist[i-1];
                end
                sum <= sum_next;
                // arithmetic shift gives the floor of sum / 4
                avg_data <= axis_t'(sum_next >>> AVG_SHIFT);
            end
        end
    end

    // one output pulse per single-cycle input strobe
    a_avg_follows_in : assert property (@(posedge iclk) disable iff (!arst_n)
        avg_valid |-> $past(in_valid) && !$past(in_valid, 2));

endmodule

// File: hw/motion_detector.sv
`timescale 1ns/1ps

module motion_detector (
    input  logic                           iclk,
    input  logic                           arst_n,
    input  logic [accel_pkg::NUM_AXES-1:0] in_valid,  // bit 2 is x
    input  accel_pkg::axis_t               in_data [accel_pkg::NUM_AXES],  // [0] is x
    output logic                           motion,
    output accel_pkg::axis_mask_t          motion_axes
);
    import accel_pkg::*;

    axis_t                    prev [NUM_AXES];
    logic signed [DIFF_W-1:0] diff [NUM_AXES];
    logic [DIFF_W-1:0]        mag  [NUM_AXES];
    axis_mask_t               hit;
    logic                     all_valid;

    assign all_valid = &in_valid;

    always_comb begin
        for (int i = 0; i < NUM_AXES; i++) begin
            diff[i] = in_data[i] - prev[i];  // widened, no wrap
            mag[i]  = diff[i][DIFF_W-1] ? -diff[i] : diff[i];
            hit[NUM_AXES-1-i] = (mag[i] > DIFF_W'(MOTION_THRESH));
        end
    end

    always_ff @(posedge iclk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_AXES; i++) begin
                prev[i] <= '0;
            end
            motion      <= 1'b0;
            motion_axes <= '0;
        end else begin
            motion <= 1'b0;
            if (all_valid) begin
                for (int i = 0; i < NUM_AXES; i++) begin
                    prev[i] <= in_data[i];
                end
                motion_axes <= hit;   // held until the next sample
                motion      <= |hit;
            end
        end
    end

    // the filters run in lock step
    a_valid_aligned : assert property (@(posedge iclk) disable iff (!arst_n)
        (in_valid == '0) || all_valid);

endmodule

// File: sim.f
hw/accel_pkg.sv
hw/accel_spi_reader.sv
hw/axis_filter.sv
hw/motion_detector.sv
hw/accel_top.sv
testbench/accel_slave_model.sv
testbench/tb_accel_top.sv

// File: testbench/accel_slave_model.sv
`timescale 1ns/1ps

module accel_slave_model (
    input  logic             sclk,
    input  logic             mosi,
    input  logic             csn,
    output logic             miso,
    output accel_pkg::axis_t x_byte,
    output accel_pkg::axis_t y_byte,
    output accel_pkg::axis_t z_byte,
    output logic [15:0]      cmd_addr  // first 16 mosi bits of the frame
);
    import accel_pkg::*;

    int                    seed;
    int                    rx_cnt;
    logic [FRAME_BITS-1:0] tx_bits;

    initial begin
        seed     = 92;
        rx_cnt   = 0;
        tx_bits  = '0;
        miso     = 1'b0;
        x_byte   = '0;
        y_byte   = '0;
        z_byte   = '0;
        cmd_addr = '0;
    end

    // fresh sample set at every frame start
    always @(negedge csn) begin
        x_byte   = axis_t'($random(seed));
        y_byte   = axis_t'($random(seed));
        z_byte   = axis_t'($random(seed));
        tx_bits  = {{TX_BITS{1'b0}}, x_byte, y_byte, z_byte};
        miso     = tx_bits[FRAME_BITS-1];  // first bit out at csn fall
        rx_cnt   = 0;
        cmd_addr = '0;
    end

    // next bit goes out on each falling sclk
    always @(negedge sclk) begin
        if (csn === 1'b0) begin
            tx_bits = tx_bits << 1;
            miso    = tx_bits[FRAME_BITS-1];
        end
    end

    // command and address, msb first
    always @(posedge sclk) begin
        if ((csn === 1'b0) && (rx_cnt < TX_BITS)) begin
            cmd_addr = {cmd_addr[TX_BITS-2:0], mosi};
            rx_cnt++;
        end
    end

endmodule

// File: testbench/tb_accel_top.sv
`timescale 1ns/1ps

module tb_accel_top;
    import accel_pkg::*;

    localparam int NUM_FRAMES     = 12;
    localparam int FRAME_CYCLES   = FRAME_BITS * BIT_CYCLES;
    localparam int TIMEOUT_CYCLES = POWER_UP_CYCLES
                                  + NUM_FRAMES * (FRAME_CYCLES + GAP_CYCLES + 2) + 1000;

    logic       iclk = 1'b0;
    logic       arst_n;
    logic       miso;
    logic       sclk;
    logic       mosi;
    logic       csn;
    logic       sample_valid;
    axis_t      x_data;
    axis_t      y_data;
    axis_t      z_data;
    logic       filt_valid;
    axis_t      filt_data [NUM_AXES];
    logic       motion;
    axis_mask_t motion_axes;

    axis_t       slave_x;
    axis_t       slave_y;
    axis_t       slave_z;
    logic [15:0] slave_cmd_addr;

    // reference model state
    int         win [NUM_AXES][AVG_DEPTH];
    axis_t      exp_avg [NUM_AXES];
    axis_t      prev_avg [NUM_AXES];
    axis_mask_t next_mask = '0;
    axis_mask_t exp_mask = '0;   // held like motion_axes
    int         since_rise = 100;  // cycles since csn rose
    int         low_cnt = 0;
    logic       csn_d = 1'b1;
    logic       started = 1'b0;
    int         frames_checked = 0;
    int         check_cnt = 0;
    int         err_cnt = 0;

    accel_top accel_top_i (
        .iclk         (iclk),
        .arst_n       (arst_n),
        .miso         (miso),
        .sclk         (sclk),
        .mosi         (mosi),
        .csn          (csn),
        .sample_valid (sample_valid),
        .x_data       (x_data),
        .y_data       (y_data),
        .z_data       (z_data),
        .filt_valid   (filt_valid),
        .filt_data    (filt_data),
        .motion       (motion),
        .motion_axes  (motion_axes)
    );

    accel_slave_model accel_slave_model_i (
        .sclk     (sclk),
        .mosi     (mosi),
        .csn      (csn),
        .miso     (miso),
        .x_byte   (slave_x),
        .y_byte   (slave_y),
        .z_byte   (slave_z),
        .cmd_addr (slave_cmd_addr)
    );

    initial begin
        forever #10 iclk = ~iclk;
    end

    task automatic check_bit(input string name, input logic exp, input logic act);
        check_cnt++;
        if (act !== exp) begin
            $display("error %0d ns: %s expected %b, got %b", $time, name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        check_cnt++;
        if (act !== exp) begin
            $display("error %0d ns: %s expected %h, got %h", $time, name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_axis(input string name, input axis_t exp, input axis_t act);
        check_cnt++;
        if (act !== exp) begin
            $display("error %0d ns: %s expected %0d, got %0d", $time, name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_mask(input string name, input axis_mask_t exp, input axis_mask_t act);
        check_cnt++;
        if (act !== exp) begin
            $display("error %0d ns: %s expected %b, got %b", $time, name, exp, act);
            err_cnt++;
        end
    endtask

    // window shift, floor average and threshold test per axis
    task automatic update_model(input axis_t x, input axis_t y, input axis_t z);
        axis_t s [NUM_AXES];
        int    sum;
        int    d;
        s[0] = x;
        s[1] = y;
        s[2] = z;
        for (int a = 0; a < NUM_AXES; a++) begin
            for (int k = AVG_DEPTH - 1; k > 0; k--) begin
                win[a][k] = win[a][k-1];
            end
            win[a][0] = int'(s[a]);
            sum = 0;
            for (int k = 0; k < AVG_DEPTH; k++) begin
                sum += win[a][k];
            end
            exp_avg[a] = axis_t'(sum >>> 2);  // floor of sum / 4
            d = int'(exp_avg[a]) - int'(prev_avg[a]);
            next_mask[NUM_AXES-1-a] = (d > MOTION_THRESH) || (-d > MOTION_THRESH);
            prev_avg[a] = exp_avg[a];
        end
    endtask

    // outputs only move on posedge, so sample on negedge
    always @(negedge iclk) begin
        if (csn === 1'b0) begin
            started = 1'b1;
            low_cnt++;
        end
        if (!started) begin
            check_bit("csn", 1'b1, csn);
            check_bit("mosi", 1'b0, mosi);
        end
        if (csn !== 1'b0) begin
            check_bit("sclk", 1'b0, sclk);
        end
        if ((csn === 1'b1) && (csn_d === 1'b0)) begin
            if (low_cnt != FRAME_CYCLES) begin
                $display("error %0d ns: csn low for %0d cycles, expected %0d",
                         $time, low_cnt, FRAME_CYCLES);
                err_cnt++;
            end
            check_byte("read command", READ_CMD, slave_cmd_addr[15:8]);
            check_byte("start address", XDATA_ADDR, slave_cmd_addr[7:0]);
            low_cnt    = 0;
            since_rise = 0;
        end else if (since_rise < 100) begin
            since_rise++;
        end
        check_bit("sample_valid", since_rise == 1, sample_valid);
        check_bit("filt_valid", since_rise == 2, filt_valid);
        if (since_rise == 1) begin
            check_axis("x_data", slave_x, x_data);
            check_axis("y_data", slave_y, y_data);
            check_axis("z_data", slave_z, z_data);
            update_model(slave_x, slave_y, slave_z);
        end
        if (since_rise == 2) begin
            for (int a = 0; a < NUM_AXES; a++) begin
                check_axis($sformatf("filt_data[%0d]", a), exp_avg[a], filt_data[a]);
            end
        end
        if (since_rise == 3) begin
            exp_mask = next_mask;
            frames_checked++;
        end
        check_bit("motion", (since_rise == 3) && (exp_mask != '0), motion);
        check_mask("motion_axes", exp_mask, motion_axes);
        csn_d = csn;
    end

    initial begin
        arst_n = 1'b0;
        for (int a = 0; a < NUM_AXES; a++) begin
            prev_avg[a] = '0;
            exp_avg[a]  = '0;
            for (int k = 0; k < AVG_DEPTH; k++) begin
                win[a][k] = 0;
            end
        end
        repeat (8) @(negedge iclk);
        arst_n = 1'b1;
        wait (frames_checked == NUM_FRAMES);
        @(negedge iclk);
        $display("frames %0d, checks %0d, errors %0d", frames_checked, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge iclk);
            cycles++;
        end
        $display("timeout after %0d cycles with only %0d of %0d frames checked",
                 cycles, frames_checked, NUM_FRAMES);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule
